/* design/obj_pkg.sv */
/* sprite layer shared definitions
   table entry, draw request and graphics ROM word formats */
package obj_pkg;

    // ROM word address is code*8 + ysub
    localparam int ROM_AW = 15;
    localparam int PEN_W  = 4;
    // shadow flag, palette, pen
    localparam int PXL_W  = 9;

    // sprite table entry, 40 bits
    // halfword 0 = {xpos, ypos}
    // halfword 1 = {pal, code}
    // halfword 2, low byte = {rsvd, shd_en, hflip}
    typedef struct packed {
        logic [5:0]  rsvd;
        logic        shd_en;
        logic        hflip;
        logic [3:0]  pal;
        logic [11:0] code;
        logic [7:0]  xpos;
        logic [7:0]  ypos;
    } obj_entry_t;

    // one sprite row to draw
    typedef struct packed {
        logic [2:0]  rsvd;
        logic        shd_en;
        logic        hflip;
        logic [3:0]  pal;
        logic [7:0]  xpos;
        logic [2:0]  ysub;
        logic [11:0] code;
    } obj_req_t;

    // eight pens for the drawer, two halfwords for readback
    // pens[7] is the leftmost pixel
    typedef union packed {
        logic [7:0][PEN_W-1:0] pens;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } halves;
    } rom_word_u;

endpackage

/* design/obj_rom_if.sv */
`timescale 1ns/1ps
/* sprite layer buses
   graphics ROM cs/ok bus and scanner to drawer request handshake */
interface obj_rom_if (
    input logic clk
);
    logic [obj_pkg::ROM_AW-1:0] addr;
    logic                       cs;
    logic                       ok;
    // valid only while ok is high
    obj_pkg::rom_word_u         data;

    // cs and addr held until ok, then cs drops for a cycle or more
    modport requester (input clk, ok, data, output addr, cs);
    modport memory    (input clk, addr, cs, output ok, data);
endinterface

interface obj_req_if;
    logic              valid;
    logic              ready;
    obj_pkg::obj_req_t req;

    // transfer when valid and ready are both high
    modport scanner (output valid, req, input ready);
    modport drawer  (input valid, req, output ready);
endinterface

/* design/obj_scan.sv */
`timescale 1ns/1ps
/* sprite table and line scanner
   finds the sprites covering the next line and issues draw requests */
module obj_scan #(
    parameter int OBJ_N = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     hs,
    input  logic [7:0]               vdump,
    input  logic                     cpu_we,
    input  logic [$clog2(OBJ_N)+1:0] cpu_addr,
    input  logic [15:0]              cpu_wdata,
    obj_req_if.scanner               req
);
    localparam int IW = $clog2(OBJ_N);

    // sprite table
    obj_pkg::obj_entry_t tbl [OBJ_N];

    logic [IW-1:0]       widx;
    logic                hs_l;
    logic                hs_rise;
    logic                busy;
    logic [IW-1:0]       idx;
    obj_pkg::obj_entry_t cur;
    logic [7:0]          dy;
    logic                hit;
    logic                step;

    assign widx = cpu_addr[IW+1:2];

    // cpu writes by halfword, select in the two low address bits
    always_ff @(posedge clk) begin
        if (cpu_we && int'(widx) < OBJ_N) begin
            case (cpu_addr[1:0])
                2'd0: begin
                    tbl[widx].ypos <= cpu_wdata[7:0];
                    tbl[widx].xpos <= cpu_wdata[15:8];
                end
                2'd1: begin
                    tbl[widx].code <= cpu_wdata[11:0];
                    tbl[widx].pal  <= cpu_wdata[15:12];
                end
                2'd2: begin
                    tbl[widx].hflip  <= cpu_wdata[0];
                    tbl[widx].shd_en <= cpu_wdata[1];
                    tbl[widx].rsvd   <= cpu_wdata[7:2];
                end
                // select 3 maps to nothing
                default: ;
            endcase
        end
    end

    assign hs_rise = hs & ~hs_l;
    assign cur     = tbl[idx];
    // row inside the sprite for the next line, wraps at 256
    assign dy      = vdump + 8'd1 - cur.ypos;
    assign hit     = dy < 8'd8;
    // visit one entry unless a pending hit is still waiting
    assign step    = busy && (!req.valid || req.ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_l      <= 1'b0;
            busy      <= 1'b0;
            idx       <= '0;
            req.valid <= 1'b0;
        end else begin
            hs_l <= hs;
            if (hs_rise) begin
                // new line, anything left over is dropped
                busy      <= 1'b1;
                idx       <= '0;
                req.valid <= 1'b0;
            end else begin
                if (req.valid && req.ready) begin
                    req.valid <= 1'b0;
                end
                if (step) begin
                    if (hit) begin
                        req.valid <= 1'b1;
                    end
                    if (idx == IW'(OBJ_N - 1)) begin
                        busy <= 1'b0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
            end
        end
    end

    // request payload, loaded on each hit
    always_ff @(posedge clk) begin
        if (step && hit && !hs_rise) begin
            req.req.rsvd   <= 3'd0;
            req.req.shd_en <= cur.shd_en;
            req.req.hflip  <= cur.hflip;
            req.req.pal    <= cur.pal;
            req.req.xpos   <= cur.xpos;
            req.req.ysub   <= dy[2:0];
            req.req.code   <= cur.code;
        end
    end

endmodule

/* design/obj_draw.sv */
`timescale 1ns/1ps
/* sprite draw engine
   fetches one ROM row per request and writes its opaque pixels to the line buffer */
module obj_draw (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      hs,
    obj_req_if.drawer                 req,
    obj_rom_if.requester              rom,
    output logic                      wr_en,
    output logic [8:0]                wr_x,
    output logic [obj_pkg::PXL_W-1:0] wr_pxl
);
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_DRAW  = 2'd2;

    logic [1:0]                st;
    logic                      hs_l;
    logic                      hs_rise;
    // fetch aborted by hs, word is thrown away
    logic                      drop;
    logic [2:0]                cnt;
    obj_pkg::obj_req_t         cur;
    obj_pkg::rom_word_u        word;
    logic [obj_pkg::PEN_W-1:0] pen;

    assign hs_rise   = hs & ~hs_l;
    // no transfer on the line boundary
    assign req.ready = st == ST_IDLE && !hs_rise;
    assign rom.addr  = {cur.code, cur.ysub};
    // pixel cnt from the left, mirrored on hflip
    assign pen       = cur.hflip ? word.pens[cnt] : word.pens[~cnt];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st     <= ST_IDLE;
            hs_l   <= 1'b0;
            drop   <= 1'b0;
            cnt    <= 3'd0;
            rom.cs <= 1'b0;
            wr_en  <= 1'b0;
        end else begin
            hs_l  <= hs;
            wr_en <= 1'b0;
            case (st)
                ST_IDLE: begin
                    if (req.valid && req.ready) begin
                        rom.cs <= 1'b1;
                        st     <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (rom.ok) begin
                        // cs low for at least one cycle after ok
                        rom.cs <= 1'b0;
                        drop   <= 1'b0;
                        cnt    <= 3'd0;
                        st     <= (drop || hs_rise) ? ST_IDLE : ST_DRAW;
                    end else if (hs_rise) begin
                        drop <= 1'b1;
                    end
                end
                ST_DRAW: begin
                    if (hs_rise) begin
                        st <= ST_IDLE;
                    end else begin
                        // pen 0 is transparent
                        wr_en <= pen != '0;
                        cnt   <= cnt + 3'd1;
                        if (cnt == 3'd7) begin
                            st <= ST_IDLE;
                        end
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    // payload, only meaningful next to cs, ok or wr_en
    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            cur <= req.req;
        end
        if (st == ST_FETCH && rom.ok) begin
            word <= rom.data;
        end
        wr_x <= {1'b0, cur.xpos} + {6'd0, cnt};
        if (pen == 4'hf && cur.shd_en) begin
            // shadow pixel: flag set, pen forced to 0
            wr_pxl <= {1'b1, cur.pal, {obj_pkg::PEN_W{1'b0}}};
        end else begin
            wr_pxl <= {1'b0, cur.pal, pen};
        end
    end

endmodule

/* design/obj_rom_arb.sv */
`timescale 1ns/1ps
/* graphics ROM arbiter
   fixed priority, draw engine over CPU readback, grant held until ok */
module obj_rom_arb (
    input  logic                       clk,
    input  logic                       rst_n,
    obj_rom_if.memory                  draw_rom,
    obj_rom_if.memory                  cpu_rom,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    output logic                       rom_cs,
    input  logic                       rom_ok,
    input  logic [31:0]                rom_data
);
    // bus granted
    logic busy;
    // owner, 0 draw and 1 cpu
    logic sel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            sel  <= 1'b0;
        end else if (!busy) begin
            // draw wins when both ask together
            if (draw_rom.cs) begin
                busy <= 1'b1;
                sel  <= 1'b0;
            end else if (cpu_rom.cs) begin
                busy <= 1'b1;
                sel  <= 1'b1;
            end
        end else if (rom_ok) begin
            busy <= 1'b0;
        end
    end

    // owner drives the ROM side
    assign rom_addr = sel ? cpu_rom.addr : draw_rom.addr;
    assign rom_cs   = busy & (sel ? cpu_rom.cs : draw_rom.cs);

    // answer goes back to the owner only
    assign draw_rom.ok   = busy & ~sel & rom_ok;
    assign cpu_rom.ok    = busy & sel & rom_ok;
    assign draw_rom.data = (busy && !sel) ? rom_data : 32'd0;
    assign cpu_rom.data  = (busy && sel) ? rom_data : 32'd0;

endmodule

/* design/obj_linebuf.sv */
`timescale 1ns/1ps
/* sprite double line buffer
   first opaque write wins, previous line plays out and clears behind itself */
module obj_linebuf #(
    parameter int LINE_W = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,
    input  logic                      hs,
    input  logic [7:0]                hdump,
    input  logic                      wr_en,
    input  logic [8:0]                wr_x,
    input  logic [obj_pkg::PXL_W-1:0] wr_pxl,
    output logic [obj_pkg::PXL_W-1:0] pxl
);
    localparam int XW = $clog2(LINE_W);

    logic [obj_pkg::PXL_W-1:0] mem [2][LINE_W];
    // draw bank, the other one is on display
    logic                      bank;
    logic                      hs_l;
    logic                      hs_rise;
    // start-up clear of both banks
    logic                      clr;
    logic [XW-1:0]             clr_x;
    logic [XW-1:0]             wa;
    logic [XW-1:0]             ra;
    logic                      wr_ok;
    logic                      rd_ok;

    assign hs_rise = hs & ~hs_l;
    assign wa      = wr_x[XW-1:0];
    assign ra      = hdump[XW-1:0];
    // off-line writes dropped, occupied pixels kept
    assign wr_ok   = wr_en && !clr && int'(wr_x) < LINE_W && mem[bank][wa] == '0;
    assign rd_ok   = !clr && int'(hdump) < LINE_W;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_l  <= 1'b0;
            bank  <= 1'b0;
            clr   <= 1'b1;
            clr_x <= '0;
            pxl   <= '0;
        end else begin
            hs_l <= hs;
            if (hs_rise) begin
                bank <= ~bank;
            end
            if (clr) begin
                clr_x <= clr_x + 1'b1;
                if (clr_x == XW'(LINE_W - 1)) begin
                    clr <= 1'b0;
                end
            end
            // blanking and clear time show transparent
            if (pxl_cen) begin
                pxl <= rd_ok ? mem[~bank][ra] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr) begin
            mem[0][clr_x] <= '0;
            mem[1][clr_x] <= '0;
        end else begin
            if (wr_ok) begin
                mem[bank][wa] <= wr_pxl;
            end
            // erase after display, ready for the next draw pass
            if (pxl_cen && rd_ok) begin
                mem[~bank][ra] <= '0;
            end
        end
    end

endmodule

/* design/obj_top.sv */
`timescale 1ns/1ps
/* sprite layer top level
   scanner, draw engine, ROM arbiter and line buffer, plus CPU ROM readback */
module obj_top #(
    parameter int OBJ_N  = 8,
    parameter int LINE_W = 64
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic                       hs,
    input  logic [7:0]                 vdump,
    input  logic [7:0]                 hdump,
    input  logic                       cpu_we,
    input  logic [$clog2(OBJ_N)+1:0]   cpu_addr,
    input  logic [15:0]                cpu_wdata,
    input  logic                       rmrd_req,
    input  logic [obj_pkg::ROM_AW:0]   rmrd_addr,
    output logic [15:0]                rmrd_data,
    output logic                       rmrd_ok,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    output logic                       rom_cs,
    input  logic                       rom_ok,
    input  logic [31:0]                rom_data,
    output logic [obj_pkg::PXL_W-1:0]  pxl
);
    logic                      wr_en;
    logic [8:0]                wr_x;
    logic [obj_pkg::PXL_W-1:0] wr_pxl;

    obj_rom_if draw_rom (.clk(clk));
    obj_rom_if cpu_rom (.clk(clk));
    obj_req_if obj_req ();

    // readback requester, rmrd_req must follow the cs/ok rule
    assign cpu_rom.addr = rmrd_addr[obj_pkg::ROM_AW:1];
    assign cpu_rom.cs   = rmrd_req;
    assign rmrd_ok      = cpu_rom.ok;
    // address bit 0 picks the high half
    assign rmrd_data    = rmrd_addr[0] ? cpu_rom.data.halves.hi : cpu_rom.data.halves.lo;

    obj_scan #(.OBJ_N(OBJ_N)) u_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .hs        (hs),
        .vdump     (vdump),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .req       (obj_req)
    );

    obj_draw u_draw (
        .clk    (clk),
        .rst_n  (rst_n),
        .hs     (hs),
        .req    (obj_req),
        .rom    (draw_rom),
        .wr_en  (wr_en),
        .wr_x   (wr_x),
        .wr_pxl (wr_pxl)
    );

    obj_rom_arb u_rom_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .draw_rom (draw_rom),
        .cpu_rom  (cpu_rom),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data)
    );

    obj_linebuf #(.LINE_W(LINE_W)) u_linebuf (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .hdump   (hdump),
        .wr_en   (wr_en),
        .wr_x    (wr_x),
        .wr_pxl  (wr_pxl),
        .pxl     (pxl)
    );

endmodule

/* test/obj_properties.sv */
`timescale 1ns/1ps
/* ROM arbiter properties
   requesters hold cs and address until ok and drop cs after it */
module obj_properties (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       busy,
    input logic                       draw_cs,
    input logic                       draw_ok,
    input logic [obj_pkg::ROM_AW-1:0] draw_addr,
    input logic                       cpu_cs,
    input logic                       cpu_ok,
    input logic [obj_pkg::ROM_AW-1:0] cpu_addr,
    input logic                       rom_cs,
    input logic                       rom_ok,
    input logic [obj_pkg::ROM_AW-1:0] rom_addr
);
    // draw engine keeps its request up until the answer
    a_draw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        draw_cs && !draw_ok |=> draw_cs && $stable(draw_addr))
        else $error("draw engine moved cs or address before ok");

    a_cpu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_cs && !cpu_ok |=> cpu_cs && $stable(cpu_addr))
        else $error("readback moved cs or address before ok");

    // each requester releases cs for a cycle after its ok
    a_draw_drop: assert property (@(posedge clk) disable iff (!rst_n)
        draw_ok |=> !draw_cs)
        else $error("draw engine cs still high after ok");

    a_cpu_drop: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ok |=> !cpu_cs)
        else $error("readback cs still high after ok");

    a_cs_steady: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom_cs or rom_addr moved before ok");

    a_ok_owned: assert property (@(posedge clk) disable iff (!rst_n)
        rom_ok |-> busy)
        else $error("rom_ok with no owner");
endmodule

bind obj_rom_arb obj_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .draw_cs   (draw_rom.cs),
    .draw_ok   (draw_rom.ok),
    .draw_addr (draw_rom.addr),
    .cpu_cs    (cpu_rom.cs),
    .cpu_ok    (cpu_rom.ok),
    .cpu_addr  (cpu_rom.addr),
    .rom_cs    (rom_cs),
    .rom_ok    (rom_ok),
    .rom_addr  (rom_addr)
);

/* test/obj_checker.sv */
`timescale 1ns/1ps
/* sprite layer checker
   compares pixels and readback halves with the expected values, reports per test */
module obj_checker #(
    parameter int OBJ_N  = 8,
    parameter int LINE_W = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [2:0]  test_id,
    input  logic        exp_vld,
    input  logic [8:0]  exp_pxl,
    input  logic [7:0]  exp_x,
    input  logic [7:0]  exp_line,
    input  logic [8:0]  pxl,
    input  logic        rmrd_ok,
    input  logic [15:0] rmrd_data,
    input  logic [15:0] exp_rmrd,
    input  logic        test_end,
    input  logic        all_done,
    output int          fail_tests
);
    int n_chk;
    int n_err;
    int n_pass;
    int n_fail;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "single_sprite";
            3'd1:    return "hflip";
            3'd2:    return "overlap";
            3'd3:    return "shadow";
            3'd4:    return "rmrd_readback";
            3'd5:    return "right_edge";
            default: return "unknown";
        endcase
    endfunction

    initial begin
        n_chk  = 0;
        n_err  = 0;
        n_pass = 0;
        n_fail = 0;
        $display("checking %0d sprites on a %0d pixel line", OBJ_N, LINE_W);
    end

    assign fail_tests = n_fail;

    always @(posedge clk) begin
        // pxl holds the value read on the previous pxl_cen
        if (rst_n && exp_vld) begin
            n_chk++;
            if (pxl !== exp_pxl) begin
                n_err++;
                $display("ERROR %s line %0d x %0d: expected %03h actual %03h",
                         test_name(test_id), exp_line, exp_x, exp_pxl, pxl);
            end
        end
        if (rst_n && rmrd_ok) begin
            n_chk++;
            if (rmrd_data !== exp_rmrd) begin
                n_err++;
                $display("ERROR %s rmrd: expected %04h actual %04h",
                         test_name(test_id), exp_rmrd, rmrd_data);
            end
        end
        // compare above goes first, the last pixel belongs to this test
        if (test_end) begin
            if (n_chk == 0) begin
                n_fail++;
                $display("%s: FAIL, nothing was compared", test_name(test_id));
            end else if (n_err == 0) begin
                n_pass++;
                $display("%s: PASS, %0d checks", test_name(test_id), n_chk);
            end else begin
                n_fail++;
                $display("%s: FAIL, %0d checks, %0d errors", test_name(test_id), n_chk, n_err);
            end
            n_chk = 0;
            n_err = 0;
        end
        if (all_done) begin
            $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        end
    end

endmodule

/* test/obj_tb.sv */
`timescale 1ns/1ps
/* sprite layer testbench
   video timing, graphics ROM model, table setup, reference model and test sequence */
module obj_tb;
    localparam int OBJ_N       = 8;
    localparam int LINE_W      = 64;
    localparam int AW          = $clog2(OBJ_N) + 2;
    localparam int LINE_PIX    = LINE_W + 16;
    localparam int LINE_CLK    = LINE_PIX * 2;
    localparam int N_TESTS     = 6;
    localparam int SKIP_LINES  = 2;
    localparam int CHECK_LINES = 32;
    localparam int TEST_LINES  = N_TESTS * (SKIP_LINES + CHECK_LINES) + SKIP_LINES;
    // twice the nominal run in ns
    localparam longint TIMEOUT_NS = 2 * TEST_LINES * LINE_CLK * 10;

    logic                       clk;
    logic                       rst_n;
    logic                       pxl_cen;
    logic                       hs;
    logic [7:0]                 vdump;
    logic [7:0]                 hdump;
    logic                       cpu_we;
    logic [AW-1:0]              cpu_addr;
    logic [15:0]                cpu_wdata;
    logic                       rmrd_req;
    logic [obj_pkg::ROM_AW:0]   rmrd_addr;
    logic [15:0]                rmrd_data;
    logic                       rmrd_ok;
    logic [obj_pkg::ROM_AW-1:0] rom_addr;
    logic                       rom_cs;
    logic                       rom_ok;
    logic [31:0]                rom_data;
    logic [obj_pkg::PXL_W-1:0]  pxl;

    // ROM model state
    integer                     seed;
    logic                       rom_busy;
    int                         rom_cnt;

    // expected values handed to the checker
    logic                       check_en;
    logic                       exp_vld;
    logic [obj_pkg::PXL_W-1:0]  exp_pxl;
    logic [7:0]                 exp_x;
    logic [7:0]                 exp_line;
    logic [15:0]                exp_rmrd;
    logic [2:0]                 test_id;
    logic                       test_end;
    logic                       all_done;
    int                         fail_tests;
    int                         other_errs;

    // copy of the sprite table
    logic [7:0]                 t_y     [OBJ_N];
    logic [7:0]                 t_x     [OBJ_N];
    logic [11:0]                t_code  [OBJ_N];
    logic [3:0]                 t_pal   [OBJ_N];
    logic                       t_hflip [OBJ_N];
    logic                       t_shd   [OBJ_N];

    obj_top #(.OBJ_N(OBJ_N), .LINE_W(LINE_W)) u_obj_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .hs        (hs),
        .vdump     (vdump),
        .hdump     (hdump),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .rmrd_req  (rmrd_req),
        .rmrd_addr (rmrd_addr),
        .rmrd_data (rmrd_data),
        .rmrd_ok   (rmrd_ok),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .pxl       (pxl)
    );

    obj_checker #(.OBJ_N(OBJ_N), .LINE_W(LINE_W)) u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .test_id    (test_id),
        .exp_vld    (exp_vld),
        .exp_pxl    (exp_pxl),
        .exp_x      (exp_x),
        .exp_line   (exp_line),
        .pxl        (pxl),
        .rmrd_ok    (rmrd_ok),
        .rmrd_data  (rmrd_data),
        .exp_rmrd   (exp_rmrd),
        .test_end   (test_end),
        .all_done   (all_done),
        .fail_tests (fail_tests)
    );

    // graphics ROM contents as a fixed mix of the address
    // odd rows end in pen 15 and rows with bit 1 set hold a pen 0
    function automatic logic [31:0] rom_word(input logic [obj_pkg::ROM_AW-1:0] a);
        logic [31:0] w;
        w = {17'd0, a} * 32'h9e3779b1;
        w = w ^ (w >> 13);
        if (a[0]) begin
            w[3:0] = 4'hf;
        end
        if (a[1]) begin
            w[23:20] = 4'h0;
        end
        return w;
    endfunction

    // address bit 0 picks the high readback half
    function automatic logic [15:0] rmrd_half(input logic [obj_pkg::ROM_AW:0] a);
        logic [31:0] w;
        w = rom_word(a[obj_pkg::ROM_AW:1]);
        return a[0] ? w[31:16] : w[15:0];
    endfunction

    // display line 0 shows what was drawn for line 32
    function automatic int drawn_line(input logic [7:0] v);
        return (v == 8'd0) ? 32 : int'(v);
    endfunction

    // lowest index with an opaque pen wins
    function automatic logic [8:0] ref_pixel(input int line, input int x);
        logic [8:0]  res;
        logic [31:0] w;
        logic [3:0]  pen;
        int          dy;
        int          col;
        int          c;
        bit          done;
        res  = '0;
        done = 0;
        for (int i = 0; i < OBJ_N; i++) begin
            dy  = (line - int'(t_y[i])) & 255;
            col = x - int'(t_x[i]);
            if (!done && dy < 8 && col >= 0 && col < 8 && x < LINE_W) begin
                w   = rom_word({t_code[i], 3'(dy)});
                c   = t_hflip[i] ? 7 - col : col;
                pen = 4'(w >> (28 - 4 * c));
                if (pen != 4'd0) begin
                    done = 1;
                    if (pen == 4'hf && t_shd[i]) begin
                        res = {1'b1, t_pal[i], 4'd0};
                    end else begin
                        res = {1'b0, t_pal[i], pen};
                    end
                end
            end
        end
        return res;
    endfunction

    always #5 clk = ~clk;

    // pxl_cen every second clock and hs high over the first pixels of a line
    always @(posedge clk) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
            hdump   <= 8'd0;
            vdump   <= 8'd0;
            hs      <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                if (hdump == 8'(LINE_PIX - 1)) begin
                    hdump <= 8'd0;
                    vdump <= (vdump == 8'd31) ? 8'd0 : vdump + 8'd1;
                    hs    <= 1'b1;
                end else begin
                    hdump <= hdump + 8'd1;
                    if (hdump == 8'd3) begin
                        hs <= 1'b0;
                    end
                end
            end
        end
    end

    // ROM model with 1 to 4 cycles from cs to a one-cycle ok
    always @(posedge clk) begin
        if (!rst_n) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
            rom_cnt  <= 0;
        end else begin
            rom_ok <= 1'b0;
            if (rom_busy) begin
                if (rom_cnt <= 1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                    rom_busy <= 1'b0;
                end else begin
                    rom_cnt <= rom_cnt - 1;
                end
            end else if (rom_cs && !rom_ok) begin
                rom_busy <= 1'b1;
                rom_cnt  <= 1 + int'($unsigned($random(seed)) % 4);
            end
        end
    end

    // expected pixel for the hdump read on this pxl_cen
    always @(posedge clk) begin
        exp_vld <= 1'b0;
        if (rst_n && pxl_cen) begin
            exp_vld  <= check_en;
            exp_pxl  <= ref_pixel(drawn_line(vdump), int'(hdump));
            exp_x    <= hdump;
            exp_line <= vdump;
        end
    end

    task automatic run_lines(input int n);
        repeat (n * LINE_CLK) @(posedge clk);
    endtask

    task automatic write_half(input int i, input int sel, input logic [15:0] d);
        @(posedge clk);
        cpu_we    <= 1'b1;
        cpu_addr  <= AW'(i * 4 + sel);
        cpu_wdata <= d;
        @(posedge clk);
        cpu_we    <= 1'b0;
    endtask

    task automatic set_sprite(input int i, input logic [7:0] y, input logic [7:0] x,
                              input logic [11:0] code, input logic [3:0] pal,
                              input logic hflip, input logic shd);
        t_y[i]     = y;
        t_x[i]     = x;
        t_code[i]  = code;
        t_pal[i]   = pal;
        t_hflip[i] = hflip;
        t_shd[i]   = shd;
        write_half(i, 0, {x, y});
        write_half(i, 1, {pal, code});
        write_half(i, 2, {14'd0, shd, hflip});
    endtask

    // park every entry below the 32-line frame
    task automatic hide_all();
        for (int i = 0; i < OBJ_N; i++) begin
            set_sprite(i, 8'd200, 8'd0, 12'd0, 4'd0, 1'b0, 1'b0);
        end
    endtask

    task automatic begin_check(input int id);
        run_lines(SKIP_LINES);
        test_id  <= 3'(id);
        check_en <= 1'b1;
    endtask

    task automatic end_check();
        check_en <= 1'b0;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    task automatic read_rom_half(input logic [obj_pkg::ROM_AW:0] a);
        int n;
        n = 0;
        @(posedge clk);
        rmrd_req  <= 1'b1;
        rmrd_addr <= a;
        exp_rmrd  <= rmrd_half(a);
        do begin
            @(posedge clk);
            n++;
        end while (!rmrd_ok && n < 64);
        if (!rmrd_ok) begin
            $display("rmrd read of %h never got rmrd_ok", a);
            other_errs++;
        end
        rmrd_req <= 1'b0;
        // cs stays low for a cycle
        @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0] r;
        clk        = 1'b0;
        rst_n      = 1'b0;
        seed       = 32'hbb28e30f;
        pxl_cen    = 1'b0;
        hs         = 1'b0;
        vdump      = 8'd0;
        hdump      = 8'd0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        rmrd_req   = 1'b0;
        rmrd_addr  = '0;
        rom_ok     = 1'b0;
        rom_data   = '0;
        check_en   = 1'b0;
        test_id    = 3'd0;
        test_end   = 1'b0;
        all_done   = 1'b0;
        exp_rmrd   = '0;
        other_errs = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        run_lines(SKIP_LINES);

        // single sprites with one crossing the frame wrap
        hide_all();
        set_sprite(0, 8'd3, 8'd5, 12'h011, 4'd3, 1'b0, 1'b0);
        set_sprite(1, 8'd20, 8'd40, 12'h02a, 4'd5, 1'b0, 1'b0);
        set_sprite(2, 8'd29, 8'd22, 12'h0b7, 4'd9, 1'b0, 1'b0);
        begin_check(0);
        run_lines(CHECK_LINES);
        end_check();

        // same sprites mirrored
        set_sprite(0, 8'd3, 8'd5, 12'h011, 4'd3, 1'b1, 1'b0);
        set_sprite(1, 8'd20, 8'd40, 12'h02a, 4'd5, 1'b1, 1'b0);
        set_sprite(2, 8'd29, 8'd22, 12'h0b7, 4'd9, 1'b1, 1'b0);
        begin_check(1);
        run_lines(CHECK_LINES);
        end_check();

        // overlap with entry 0 in front
        // entry 0 has a pen 0 at x 12 on rows 2, 3, 6 and 7
        hide_all();
        set_sprite(0, 8'd8, 8'd10, 12'h033, 4'd2, 1'b0, 1'b0);
        set_sprite(1, 8'd10, 8'd12, 12'h044, 4'd7, 1'b0, 1'b0);
        begin_check(2);
        run_lines(CHECK_LINES);
        end_check();

        // shadow on and off for the same code
        hide_all();
        set_sprite(0, 8'd4, 8'd8, 12'h055, 4'd6, 1'b0, 1'b1);
        set_sprite(1, 8'd14, 8'd30, 12'h055, 4'd6, 1'b0, 1'b0);
        set_sprite(2, 8'd18, 8'd33, 12'h066, 4'd1, 1'b1, 1'b1);
        begin_check(3);
        run_lines(CHECK_LINES);
        end_check();

        // readback while drawing
        hide_all();
        set_sprite(0, 8'd8, 8'd10, 12'h033, 4'd2, 1'b0, 1'b0);
        set_sprite(1, 8'd10, 8'd13, 12'h044, 4'd7, 1'b1, 1'b1);
        begin_check(4);
        fork
            run_lines(CHECK_LINES);
            begin
                repeat (40) begin
                    r = $random(seed);
                    read_rom_half(r[obj_pkg::ROM_AW:0]);
                    repeat (20) @(posedge clk);
                end
            end
        join
        end_check();

        // right edge clipping and a sprite at x 0
        hide_all();
        set_sprite(0, 8'd4, 8'd60, 12'h077, 4'd4, 1'b0, 1'b0);
        set_sprite(1, 8'd6, 8'(LINE_W + 2), 12'h088, 4'd8, 1'b0, 1'b0);
        set_sprite(2, 8'd5, 8'd0, 12'h099, 4'd10, 1'b0, 1'b0);
        begin_check(5);
        run_lines(CHECK_LINES);
        end_check();

        all_done <= 1'b1;
        @(posedge clk);
        all_done <= 1'b0;
        @(posedge clk);
        if (fail_tests == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
design/obj_pkg.sv
design/obj_rom_if.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_rom_arb.sv
design/obj_linebuf.sv
design/obj_top.sv
test/obj_properties.sv
test/obj_checker.sv
test/obj_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module obj_tb

sim:
	verilator --binary --timing --assert -f list.f --top-module obj_tb \
		--Mdir obj_dir -o obj_sim
	./obj_dir/obj_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
